/* logic/trig_pkg.sv */
`default_nettype none

package trig_pkg;

	// ************************************************************************
	// Constants
	// ************************************************************************

	// Width of the running event counter
	localparam int count_width = 8;

	// Index width for a channel select is at least one bit
	function automatic int idx_width(input int n);
		if (n > 1)
			return $clog2(n);
		return 1;
	endfunction

	// ************************************************************************
	// Types
	// ************************************************************************

	// The hit is the OR of all selected conditions
	typedef struct packed {
		logic high;
		logic low;
		logic eq;
		logic rise;
		logic fall;
	} trig_cond_t;

	// Per-channel control word from the low 7 bits of a REG_CTRL write
	typedef struct packed {
		logic       enable;
		logic       is_signed;
		trig_cond_t cond;
	} trig_cfg_t;

	typedef enum logic [1:0] {
		TRIG_IDLE   = 2'd0,
		TRIG_SAMPLE = 2'd1,
		TRIG_ARMED  = 2'd2,
		TRIG_FIRED  = 2'd3
	} trig_state_e;

	// Register select that doubles as the write opcode
	typedef enum logic [0:0] {
		REG_CTRL = 1'b0,
		REG_REF  = 1'b1
	} trig_reg_e;

endpackage

`default_nettype wire

/* logic/trig_cfg_regs.sv */
`default_nettype none

module trig_cfg_regs
	import trig_pkg::*;
#(
	parameter int num_channels = 4,
	parameter int sample_width = 8,
	localparam int chan_width = idx_width(num_channels)
)
(
	input wire                                      rvx_port_5,
	input wire                                      rvx_port_6,
	input wire                                      cfg_write,
	input wire [chan_width-1:0]                     cfg_channel,
	input wire trig_reg_e                           cfg_reg,
	input wire [sample_width-1:0]                   cfg_data,
	output trig_cfg_t [num_channels-1:0]            chan_cfg,
	output logic [num_channels-1:0][sample_width-1:0] chan_ref,
	output logic [num_channels-1:0]                 arm_clear
);

	localparam int cfg_width = $bits(trig_cfg_t);
	// Data padded so that narrow samples still yield a full control word
	localparam int pad_width = (sample_width > cfg_width) ? sample_width : cfg_width;

	logic [pad_width-1:0] data_ext;
	trig_cfg_t            cfg_word;
	logic [num_channels-1:0] chan_sel;

	assign data_ext = pad_width'(cfg_data);
	assign cfg_word = trig_cfg_t'(data_ext[cfg_width-1:0]);

	// One-hot decode of the addressed channel
	always_comb
	begin
		chan_sel = '0;
		for (int i = 0; i < num_channels; i++)
		begin
			if (cfg_channel == chan_width'(i))
				chan_sel[i] = 1'b1;
		end
	end

	// ************************************************************************
	// Configuration and reference registers
	// ************************************************************************

	always_ff @(posedge rvx_port_5, negedge rvx_port_6)
	begin
		if (!rvx_port_6)
		begin
			chan_cfg  <= '0;
			chan_ref  <= '0;
			arm_clear <= '0;
		end
		else
		begin
			// Re-arm pulse lasts one cycle only
			arm_clear <= '0;
			for (int i = 0; i < num_channels; i++)
			begin
				if (cfg_write && chan_sel[i])
				begin
					case (cfg_reg)
						REG_CTRL:
						begin
							chan_cfg[i]  <= cfg_word;
							arm_clear[i] <= 1'b1;
						end
						REG_REF:
							chan_ref[i] <= cfg_data;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/trig_cond_detector.sv */
`default_nettype none

module trig_cond_detector
	import trig_pkg::*;
#(
	parameter int sample_width = 8
)
(
	input wire                    rvx_port_5,
	input wire                    rvx_port_6,
	input wire trig_cfg_t         cfg,
	input wire                    arm_clear,
	input wire [sample_width-1:0] sample,
	input wire [sample_width-1:0] ref_value,
	output logic                  hit
);

	trig_state_e state;
	logic [sample_width-1:0] prev_sample;

	// Differences are one bit wider than a sample so they cannot overflow
	logic [sample_width:0] diff_ref;
	logic [sample_width:0] diff_prev;

	logic ref_gt;
	logic ref_lt;
	logic ref_eq;
	logic prev_gt;
	logic prev_lt;
	logic cond_hit;

	// Sign or zero extend both operands before the subtraction
	function automatic logic [sample_width:0] ext_diff(
		input logic [sample_width-1:0] a,
		input logic [sample_width-1:0] b,
		input logic                    is_signed
	);
		logic [sample_width:0] a_ext;
		logic [sample_width:0] b_ext;
		a_ext = {is_signed & a[sample_width-1], a};
		b_ext = {is_signed & b[sample_width-1], b};
		return a_ext - b_ext;
	endfunction

	// ************************************************************************
	// Arm sequence
	// ************************************************************************

	always_ff @(posedge rvx_port_5, negedge rvx_port_6)
	begin
		if (!rvx_port_6)
			state <= TRIG_IDLE;
		else if (arm_clear)
			state <= TRIG_IDLE;
		else if (!cfg.enable)
			state <= TRIG_IDLE;
		else
		begin
			case (state)
				TRIG_IDLE:
					state <= TRIG_SAMPLE;
				TRIG_SAMPLE:
					state <= TRIG_ARMED;
				TRIG_ARMED:
				begin
					if (cond_hit)
						state <= TRIG_FIRED;
				end
				default:
					// Stays fired until re-armed or disabled
					state <= TRIG_FIRED;
			endcase
		end
	end

	// Previous sample follows the input while sampling or armed
	always_ff @(posedge rvx_port_5, negedge rvx_port_6)
	begin
		if (!rvx_port_6)
			prev_sample <= '0;
		else if ((state == TRIG_SAMPLE) || (state == TRIG_ARMED))
			prev_sample <= sample;
	end

	// ************************************************************************
	// Compare
	// ************************************************************************

	assign diff_ref  = ext_diff(sample, ref_value, cfg.is_signed);
	assign diff_prev = ext_diff(sample, prev_sample, cfg.is_signed);

	// MSB of the difference is its sign
	assign ref_lt  = diff_ref[sample_width];
	assign ref_eq  = (diff_ref == '0);
	assign ref_gt  = !ref_lt && !ref_eq;
	assign prev_lt = diff_prev[sample_width];
	assign prev_gt = !prev_lt && (diff_prev != '0);

	assign cond_hit = (cfg.cond.high & ref_gt)
		| (cfg.cond.low & ref_lt)
		| (cfg.cond.eq & ref_eq)
		| (cfg.cond.rise & prev_gt)
		| (cfg.cond.fall & prev_lt);

	always_comb
	begin
		case (state)
			TRIG_ARMED:
				hit = cond_hit;
			TRIG_FIRED:
				hit = 1'b1;
			default:
				hit = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/trig_event_collector.sv */
`default_nettype none

module trig_event_collector
	import trig_pkg::*;
#(
	parameter int num_channels = 4,
	localparam int chan_width = idx_width(num_channels)
)
(
	input wire                     rvx_port_5,
	input wire                     rvx_port_6,
	input wire [num_channels-1:0]  hits,
	output logic                   irq,
	output logic [count_width-1:0] event_count,
	output logic [chan_width-1:0]  last_channel
);

	logic [num_channels-1:0] hits_q;
	logic [num_channels-1:0] new_edge;
	logic [count_width-1:0]  edge_count;
	logic [chan_width-1:0]   first_idx;

	// A hit counts once on the cycle it goes high
	assign new_edge = hits & ~hits_q;

	// Number of channels that fired this cycle
	always_comb
	begin
		edge_count = '0;
		for (int i = 0; i < num_channels; i++)
			edge_count = edge_count + count_width'(new_edge[i]);
	end

	// Scan downwards so the lowest set index wins
	always_comb
	begin
		first_idx = '0;
		for (int i = num_channels - 1; i >= 0; i--)
		begin
			if (new_edge[i])
				first_idx = chan_width'(i);
		end
	end

	// ************************************************************************
	// Event state
	// ************************************************************************

	always_ff @(posedge rvx_port_5, negedge rvx_port_6)
	begin
		if (!rvx_port_6)
		begin
			hits_q       <= '0;
			irq          <= 1'b0;
			event_count  <= '0;
			last_channel <= '0;
		end
		else
		begin
			hits_q <= hits;
			irq    <= |new_edge;
			if (|new_edge)
			begin
				// Counter wraps on overflow
				event_count  <= event_count + edge_count;
				last_channel <= first_idx;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/trig_unit_top.sv */
`default_nettype none

module trig_unit_top
	import trig_pkg::*;
#(
	parameter int num_channels = 4,
	parameter int sample_width = 8,
	localparam int chan_width = idx_width(num_channels)
)
(
	input wire                                    rvx_port_5,
	input wire                                    rvx_port_6,
	input wire                                    cfg_write,
	input wire [chan_width-1:0]                   cfg_channel,
	input wire trig_reg_e                         cfg_reg,
	input wire [sample_width-1:0]                 cfg_data,
	input wire [num_channels-1:0][sample_width-1:0] samples,
	output logic [num_channels-1:0]               hits,
	output logic                                  irq,
	output logic [count_width-1:0]                event_count,
	output logic [chan_width-1:0]                 last_channel
);

	trig_cfg_t [num_channels-1:0]              chan_cfg;
	logic [num_channels-1:0][sample_width-1:0] chan_ref;
	logic [num_channels-1:0]                   arm_clear;

	// ************************************************************************
	// Register block
	// ************************************************************************

	trig_cfg_regs #(
		.num_channels (num_channels),
		.sample_width (sample_width)
	) i_trig_cfg_regs (
		.rvx_port_5  (rvx_port_5),
		.rvx_port_6  (rvx_port_6),
		.cfg_write   (cfg_write),
		.cfg_channel (cfg_channel),
		.cfg_reg     (cfg_reg),
		.cfg_data    (cfg_data),
		.chan_cfg    (chan_cfg),
		.chan_ref    (chan_ref),
		.arm_clear   (arm_clear)
	);

	// One detector per channel
	for (genvar g = 0; g < num_channels; g++)
	begin : g_det
		trig_cond_detector #(
			.sample_width (sample_width)
		) i_trig_cond_detector (
			.rvx_port_5 (rvx_port_5),
			.rvx_port_6 (rvx_port_6),
			.cfg        (chan_cfg[g]),
			.arm_clear  (arm_clear[g]),
			.sample     (samples[g]),
			.ref_value  (chan_ref[g]),
			.hit        (hits[g])
		);
	end

	trig_event_collector #(
		.num_channels (num_channels)
	) i_trig_event_collector (
		.rvx_port_5   (rvx_port_5),
		.rvx_port_6   (rvx_port_6),
		.hits         (hits),
		.irq          (irq),
		.event_count  (event_count),
		.last_channel (last_channel)
	);

endmodule

`default_nettype wire

/* tb/trig_unit_checks.svh */
`ifndef TRIG_UNIT_CHECKS_SVH
`define TRIG_UNIT_CHECKS_SVH

// ****************************************************************************
// Compare tasks and bounded waits
// ****************************************************************************

task automatic stop_on_error(input string msg);
	$display("%s", msg);
	$display("Some tests failed");
	$fatal(1, "simulation stopped at first error");
endtask

task automatic check_hits(
	input string                   name,
	input logic [num_channels-1:0] exp,
	input logic [num_channels-1:0] act
);
	if (act !== exp)
		stop_on_error($sformatf("** Error: %s hits expected %h actual %h", name, exp, act));
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
	if (act !== exp)
		stop_on_error($sformatf("** Error: %s irq expected %b actual %b", name, exp, act));
endtask

task automatic check_count(
	input string                  name,
	input logic [count_width-1:0] exp,
	input logic [count_width-1:0] act
);
	if (act !== exp)
		stop_on_error($sformatf("** Error: %s event_count expected %h actual %h",
			name, exp, act));
endtask

task automatic check_channel(
	input string                 name,
	input logic [chan_width-1:0] exp,
	input logic [chan_width-1:0] act
);
	if (act !== exp)
		stop_on_error($sformatf("** Error: %s last_channel expected %h actual %h",
			name, exp, act));
endtask

// Returns at the falling edge where irq is seen high
task automatic wait_for_irq(input int max_cycles);
	int n;
	n = 0;
	while (irq !== 1'b1)
	begin
		if (n >= max_cycles)
			stop_on_error($sformatf("Timeout: irq did not rise within %0d cycles", max_cycles));
		@(negedge rvx_port_5);
		n++;
	end
endtask

`endif

/* tb/tb_trig_unit.sv */
`default_nettype none

module tb_trig_unit
	import trig_pkg::*;
();

	localparam int num_channels = 4;
	localparam int sample_width = 8;
	localparam int chan_width = idx_width(num_channels);

	logic                                      rvx_port_5;
	logic                                      rvx_port_6;
	logic                                      cfg_write;
	logic [chan_width-1:0]                     cfg_channel;
	trig_reg_e                                 cfg_reg;
	logic [sample_width-1:0]                   cfg_data;
	logic [num_channels-1:0][sample_width-1:0] samples;
	logic [num_channels-1:0]                   hits;
	logic                                      irq;
	logic [count_width-1:0]                    event_count;
	logic [chan_width-1:0]                     last_channel;

	// Model state written by the stimulus
	trig_cfg_t               cfg_m [num_channels];
	logic [sample_width-1:0] ref_m [num_channels];
	logic [num_channels-1:0] armed_m;
	logic [num_channels-1:0] watch;
	logic                    checks_on;
	string                   test_name;

	// Model state owned by the comparing process
	logic [num_channels-1:0] latched_m;
	logic [sample_width-1:0] prev_m [num_channels];
	logic [num_channels-1:0] exp_prev_hits;
	logic                    exp_irq;
	logic [count_width-1:0]  exp_count;
	logic [chan_width-1:0]   exp_last;

	`include "trig_unit_checks.svh"

	trig_unit_top i_trig_unit_top (
		.rvx_port_5   (rvx_port_5),
		.rvx_port_6   (rvx_port_6),
		.cfg_write    (cfg_write),
		.cfg_channel  (cfg_channel),
		.cfg_reg      (cfg_reg),
		.cfg_data     (cfg_data),
		.samples      (samples),
		.hits         (hits),
		.irq          (irq),
		.event_count  (event_count),
		.last_channel (last_channel)
	);

	initial
	begin
		rvx_port_5 = 1'b0;
		forever #5 rvx_port_5 = ~rvx_port_5;
	end

	// ************************************************************************
	// Reference model
	// ************************************************************************

	function automatic logic expected_hit(
		input trig_cfg_t               cfg,
		input logic [sample_width-1:0] ref_v,
		input logic [sample_width-1:0] prev_v,
		input logic [sample_width-1:0] cur_v
	);
		logic above_ref;
		logic below_ref;
		logic above_prev;
		logic below_prev;
		if (cfg.is_signed)
		begin
			above_ref  = $signed(cur_v) > $signed(ref_v);
			below_ref  = $signed(cur_v) < $signed(ref_v);
			above_prev = $signed(cur_v) > $signed(prev_v);
			below_prev = $signed(cur_v) < $signed(prev_v);
		end
		else
		begin
			above_ref  = cur_v > ref_v;
			below_ref  = cur_v < ref_v;
			above_prev = cur_v > prev_v;
			below_prev = cur_v < prev_v;
		end
		return (cfg.cond.high && above_ref) || (cfg.cond.low && below_ref)
			|| (cfg.cond.eq && (cur_v == ref_v))
			|| (cfg.cond.rise && above_prev) || (cfg.cond.fall && below_prev);
	endfunction

	// Outputs are stable at the falling edge
	always @(negedge rvx_port_5)
	begin : compare_outputs
		logic [num_channels-1:0] exp_hits;
		logic [num_channels-1:0] new_hits;
		if (!checks_on)
		begin
			latched_m     = '0;
			exp_prev_hits = '0;
			exp_irq       = 1'b0;
			exp_count     = '0;
			exp_last      = '0;
		end
		else
		begin
			for (int c = 0; c < num_channels; c++)
				exp_hits[c] = watch[c] && armed_m[c] && (latched_m[c]
					|| expected_hit(cfg_m[c], ref_m[c], prev_m[c], samples[c]));
			check_hits(test_name, exp_hits, hits & watch);
			check_irq(test_name, exp_irq, irq);
			check_count(test_name, exp_count, event_count);
			check_channel(test_name, exp_last, last_channel);
			// Collector answers one cycle after a new edge
			new_hits = exp_hits & ~exp_prev_hits;
			exp_irq  = |new_hits;
			for (int c = num_channels - 1; c >= 0; c--)
			begin
				if (new_hits[c])
				begin
					exp_count = exp_count + count_width'(1);
					exp_last  = chan_width'(c);
				end
			end
			for (int c = 0; c < num_channels; c++)
				latched_m[c] = watch[c] && (latched_m[c] || exp_hits[c]);
			exp_prev_hits = exp_hits;
		end
		for (int c = 0; c < num_channels; c++)
			prev_m[c] = samples[c];
	end

	// ************************************************************************
	// Stimulus helpers
	// ************************************************************************

	task automatic step(input int n);
		repeat (n) @(posedge rvx_port_5);
		#1;
	endtask

	task automatic write_reg(input int ch, input trig_reg_e sel,
		input logic [sample_width-1:0] data);
		cfg_write   = 1'b1;
		cfg_channel = chan_width'(ch);
		cfg_reg     = sel;
		cfg_data    = data;
		step(1);
		cfg_write = 1'b0;
	endtask

	task automatic set_ref(input int ch, input logic [sample_width-1:0] value);
		write_reg(ch, REG_REF, value);
		ref_m[ch] = value;
	endtask

	// Channel is unwatched while its arm sequence restarts
	task automatic configure(input int ch, input trig_cfg_t cfg);
		write_reg(ch, REG_CTRL, '0);
		watch[ch]   = 1'b0;
		armed_m[ch] = 1'b0;
		cfg_m[ch]   = cfg;
		write_reg(ch, REG_CTRL, sample_width'(cfg));
		// Clear, idle, sample
		step(3);
		armed_m[ch] = cfg.enable;
		watch[ch]   = 1'b1;
		step(3);
	endtask

	task automatic probe_hit(input string name, input int ch, input logic value);
		@(negedge rvx_port_5);
		check_hits(name, num_channels'(value) << ch, hits & (num_channels'(1) << ch));
		step(1);
	endtask

	function automatic trig_cfg_t make_cfg(input logic is_signed, input logic [4:0] cond_bits);
		trig_cfg_t cfg;
		cfg.enable    = 1'b1;
		cfg.is_signed = is_signed;
		cfg.cond      = trig_cond_t'(cond_bits);
		return cfg;
	endfunction

	// ************************************************************************
	// Test flow
	// ************************************************************************

	initial
	begin : run_tests
		trig_cfg_t               cfg;
		logic [sample_width-1:0] ref_v;
		logic [sample_width-1:0] smp;
		logic [count_width-1:0]  base;
		void'($urandom(32'h4aa50820));
		rvx_port_6  = 1'b0;
		cfg_write   = 1'b0;
		cfg_channel = '0;
		cfg_reg     = REG_CTRL;
		cfg_data    = '0;
		samples     = '0;
		watch       = '1;
		armed_m     = '0;
		checks_on   = 1'b0;
		test_name   = "reset";
		for (int c = 0; c < num_channels; c++)
		begin
			cfg_m[c] = '0;
			ref_m[c] = '0;
		end
		step(10);
		rvx_port_6 = 1'b1;
		checks_on  = 1'b1;

		test_name = "idle";
		for (int i = 0; i < 20; i++)
		begin
			for (int c = 0; c < num_channels; c++)
				samples[c] = sample_width'($urandom);
			step(1);
		end

		// High, low and eq alone in unsigned then signed mode
		test_name = "level";
		for (int mode = 0; mode < 2; mode++)
			for (int k = 0; k < 3; k++)
				for (int t = 0; t < 6; t++)
				begin
					ref_v = sample_width'($urandom);
					smp   = sample_width'($urandom);
					case (t)
						0:
						begin
							ref_v = 8'h7f;
							smp   = 8'h80;
						end
						1:
						begin
							ref_v = 8'h80;
							smp   = 8'h7f;
						end
						2:
							smp = ref_v;
						3:
							smp = ref_v - 1'b1;
						default:
							;
					endcase
					samples[0] = smp;
					set_ref(0, ref_v);
					configure(0, make_cfg(mode[0], 5'b10000 >> k));
					step(2);
				end

		test_name = "edge";
		samples[1] = 8'd50;
		configure(1, make_cfg(1'b0, 5'b00010));
		probe_hit("edge_steady", 1, 1'b0);
		samples[1] = 8'd60;
		probe_hit("edge_rise", 1, 1'b1);
		configure(1, make_cfg(1'b0, 5'b00001));
		samples[1] = 8'd40;
		probe_hit("edge_fall", 1, 1'b1);
		samples[1] = 8'h7f;
		configure(1, make_cfg(1'b1, 5'b00010));
		samples[1] = 8'h80;
		probe_hit("edge_signed_wrap", 1, 1'b0);
		samples[1] = 8'h7f;
		configure(1, make_cfg(1'b0, 5'b00010));
		samples[1] = 8'h80;
		probe_hit("edge_unsigned_wrap", 1, 1'b1);

		test_name = "latch";
		samples[2] = 8'd50;
		set_ref(2, 8'd100);
		configure(2, make_cfg(1'b0, 5'b10000));
		probe_hit("latch_quiet", 2, 1'b0);
		samples[2] = 8'd150;
		probe_hit("latch_fire", 2, 1'b1);
		samples[2] = 8'd50;
		step(3);
		probe_hit("latch_hold", 2, 1'b1);
		configure(2, make_cfg(1'b0, 5'b10000));
		probe_hit("rearm_clear", 2, 1'b0);
		samples[2] = 8'd150;
		probe_hit("rearm_fire", 2, 1'b1);

		test_name = "collector";
		samples[0] = 8'd10;
		samples[3] = 8'd10;
		set_ref(0, 8'd200);
		set_ref(3, 8'd200);
		configure(0, make_cfg(1'b0, 5'b10000));
		configure(3, make_cfg(1'b0, 5'b10000));
		base = exp_count;
		samples[3] = 8'd250;
		wait_for_irq(8);
		check_count("collector_single", base + count_width'(1), event_count);
		check_channel("collector_single", chan_width'(3), last_channel);
		step(1);
		samples[3] = 8'd10;
		configure(0, make_cfg(1'b0, 5'b10000));
		configure(3, make_cfg(1'b0, 5'b10000));
		base = exp_count;
		samples[0] = 8'd250;
		samples[3] = 8'd250;
		wait_for_irq(8);
		check_count("collector_pair", base + count_width'(2), event_count);
		check_channel("collector_pair", chan_width'(0), last_channel);
		step(1);

		test_name = "ref_write";
		samples[0] = 8'd120;
		samples[1] = 8'd120;
		set_ref(0, 8'd200);
		set_ref(1, 8'd200);
		configure(0, make_cfg(1'b0, 5'b10000));
		configure(1, make_cfg(1'b0, 5'b10000));
		probe_hit("ref_before", 0, 1'b0);
		set_ref(0, 8'd100);
		probe_hit("ref_changed", 0, 1'b1);
		probe_hit("ref_other", 1, 1'b0);

		test_name = "disabled";
		cfg = make_cfg(1'b0, 5'b11111);
		cfg.enable = 1'b0;
		configure(3, cfg);
		for (int i = 0; i < 20; i++)
		begin
			samples[3] = sample_width'($urandom);
			step(1);
		end
		probe_hit("disabled_quiet", 3, 1'b0);

		step(2);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
logic/trig_pkg.sv
logic/trig_cfg_regs.sv
logic/trig_cond_detector.sv
logic/trig_event_collector.sv
logic/trig_unit_top.sv
tb/tb_trig_unit.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_trig_unit
FILELIST   := tb.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
